/* include/panel_defs.svh */
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// Datapath word and register file size
`define DATA_W     16
`define REG_COUNT  16
`define REG_AW     4     // Register number width

// Operator panel
`define SW_W       10    // Slide switches
`define OP_W       5     // Opcode field of the switch word

// Display
`define DIGITS     4
`define NIBBLE_W   4
`define SEG_W      7     // Segments gfedcba

`endif

/* hdl/aluPkg.sv */
`include "panel_defs.svh"

package aluPkg;

	// Opcodes; any value not listed is treated as invalid
	typedef enum logic [`OP_W-1:0] {
		OP_ADD = 0,
		OP_SUB = 1,
		OP_AND = 2,
		OP_OR  = 3,
		OP_XOR = 4,
		OP_MOV = 5,
		OP_LSH = 6,   // Shift left by b[3:0]
		OP_CMP = 7    // Subtract without write-back
	} opCode_e;

	// Condition flags kept after each operation
	typedef struct packed {
		logic carry;     // Carry out, or borrow on subtract
		logic low;       // Unsigned a < b
		logic overflow;  // Signed overflow
		logic zero;
		logic negative;
	} flags_t;

endpackage

/* hdl/panelPkg.sv */
`include "panel_defs.svh"

package panelPkg;

	// Opcode load: immediate select in the top bit, opcode in the low bits
	typedef struct packed {
		logic                            immSel;
		logic [`SW_W-`OP_W-2:0]          spare;
		aluPkg::opCode_e                 opCode;
	} opView_t;

	// Register load: dest on the left switches, src on the right
	typedef struct packed {
		logic [`REG_AW-1:0]              dest;
		logic [`SW_W-2*`REG_AW-1:0]      spare;
		logic [`REG_AW-1:0]              src;
	} regView_t;

	// Control load: only the two rightmost switches matter
	typedef struct packed {
		logic [`SW_W-3:0]                spare;
		logic                            enable;
		logic                            clear;
	} ctrlView_t;

	typedef union packed {
		logic [`SW_W-1:0]                raw;       // Immediate load
		opView_t                         opView;
		regView_t                        regView;
		ctrlView_t                       ctrlView;
	} switchWord_u;

	// Operator control registers
	typedef struct packed {
		aluPkg::opCode_e                 opCode;
		logic                            immSel;
		logic [`DATA_W-1:0]              imm;       // Already sign-extended
		logic [`REG_AW-1:0]              dest;
		logic [`REG_AW-1:0]              src;
		logic                            enable;
		logic                            clear;
	} panelCtrl_t;

endpackage

/* hdl/panelLatch.sv */
`include "panel_defs.svh"

module panelLatch (
	input  logic                  clk,
	input  logic                  reset,
	input  panelPkg::switchWord_u switches,
	input  logic                  ldOp,
	input  logic                  ldImm,
	input  logic                  ldReg,
	input  logic                  ldCtrl,
	output panelPkg::panelCtrl_t  ctrl
);

	logic [`DATA_W-1:0] immExt;

	// Sign-extend the raw switch value to the datapath width
	assign immExt = {{(`DATA_W-`SW_W){switches.raw[`SW_W-1]}}, switches.raw};

	// Each strobe owns its own fields, so strobes may coincide
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= '0;  // Leaves enable low
		end else begin
			if (ldOp) begin
				ctrl.opCode <= switches.opView.opCode;
				ctrl.immSel <= switches.opView.immSel;
			end

			if (ldImm) begin
				ctrl.imm <= immExt;
			end

			if (ldReg) begin
				ctrl.dest <= switches.regView.dest;
				ctrl.src  <= switches.regView.src;
			end

			if (ldCtrl) begin
				ctrl.enable <= switches.ctrlView.enable;
				ctrl.clear  <= switches.ctrlView.clear;
			end
		end
	end

endmodule

/* hdl/regFile.sv */
`include "panel_defs.svh"

module regFile (
	input  logic               clk,
	input  logic               reset,
	input  logic               clear,
	input  logic               we,
	input  logic [`REG_AW-1:0] wAddr,
	input  logic [`REG_AW-1:0] rAddrA,
	input  logic [`REG_AW-1:0] rAddrB,
	input  logic [`DATA_W-1:0] wData,
	output logic [`DATA_W-1:0] rDataA,
	output logic [`DATA_W-1:0] rDataB
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;  // Whole file zeroed
			end
		end else if (we) begin
			regs[wAddr] <= wData;
		end
	end

	assign rDataA = regs[rAddrA];  // Combinational reads
	assign rDataB = regs[rAddrB];

endmodule

/* hdl/alu.sv */
`include "panel_defs.svh"

module alu (
	input  aluPkg::opCode_e    opCode,
	input  logic [`DATA_W-1:0] a,
	input  logic [`DATA_W-1:0] b,
	output logic [`DATA_W-1:0] aluResult,
	output logic               writeBack,
	output logic               valid,
	output aluPkg::flags_t     newFlags
);

	import aluPkg::*;

	logic [`DATA_W:0] sum;   // Extra bit holds the carry
	logic [`DATA_W:0] diff;  // Extra bit holds the borrow
	logic             addOvf;
	logic             subOvf;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	// Same-sign operands giving a different-sign sum
	assign addOvf = (a[`DATA_W-1] == b[`DATA_W-1]) &&
	                (sum[`DATA_W-1] != a[`DATA_W-1]);
	// Opposite signs with the result taking the sign of b
	assign subOvf = (a[`DATA_W-1] != b[`DATA_W-1]) &&
	                (diff[`DATA_W-1] != a[`DATA_W-1]);

	always_comb begin
		aluResult = '0;
		valid     = 1'b1;
		newFlags  = '0;  // Undefined flags stay cleared

		case (opCode)
			OP_ADD: begin
				aluResult         = sum[`DATA_W-1:0];
				newFlags.carry    = sum[`DATA_W];
				newFlags.overflow = addOvf;
			end
			OP_SUB, OP_CMP: begin
				aluResult         = diff[`DATA_W-1:0];
				newFlags.carry    = diff[`DATA_W];  // Borrow
				newFlags.low      = diff[`DATA_W];  // Unsigned a < b
				newFlags.overflow = subOvf;
			end
			OP_AND: aluResult = a & b;
			OP_OR:  aluResult = a | b;
			OP_XOR: aluResult = a ^ b;
			OP_MOV: aluResult = b;
			OP_LSH: aluResult = a << b[3:0];
			default: begin
				valid = 1'b0;
			end
		endcase

		// Follow the 16-bit value for every opcode
		newFlags.zero     = (aluResult == '0);
		newFlags.negative = aluResult[`DATA_W-1];

		// Compare only sets flags
		writeBack = valid && (opCode != OP_CMP);
	end

endmodule

/* hdl/regFileAlu.sv */
`include "panel_defs.svh"

module regFileAlu (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 exec,
	input  panelPkg::panelCtrl_t ctrl,
	output logic [`DATA_W-1:0]   result,
	output aluPkg::flags_t       flags
);

	import aluPkg::*;

	logic [`DATA_W-1:0] destData;
	logic [`DATA_W-1:0] srcData;
	logic [`DATA_W-1:0] operand;
	logic [`DATA_W-1:0] aluResult;
	logic               writeBack;
	logic               aluValid;
	logic               execOk;
	flags_t             newFlags;

	// Exec counts only when enabled, not clearing, and the opcode is defined
	assign execOk = exec && ctrl.enable && !ctrl.clear && aluValid;

	assign operand = ctrl.immSel ? ctrl.imm : srcData;  // Immediate or register

	regFile regFile_i (
		.clk    (clk),
		.reset  (reset),
		.clear  (ctrl.clear),
		.we     (execOk && writeBack),
		.wAddr  (ctrl.dest),
		.rAddrA (ctrl.dest),
		.rAddrB (ctrl.src),
		.wData  (aluResult),
		.rDataA (destData),
		.rDataB (srcData)
	);

	alu alu_i (
		.opCode    (ctrl.opCode),
		.a         (destData),
		.b         (operand),
		.aluResult (aluResult),
		.writeBack (writeBack),
		.valid     (aluValid),
		.newFlags  (newFlags)
	);

	// Last result and flags, CMP included
	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			flags  <= '0;
		end else if (execOk) begin
			result <= aluResult;
			flags  <= newFlags;
		end
	end

endmodule

/* hdl/hexTo7Seg.sv */
`include "panel_defs.svh"

module hexTo7Seg (
	input  logic [`NIBBLE_W-1:0] x,
	output logic [`SEG_W-1:0]    z
);

	// Patterns written active high as gfedcba, then inverted for the board
	always_comb begin
		case (x)
			4'h0: z = ~7'b0111111;
			4'h1: z = ~7'b0000110;
			4'h2: z = ~7'b1011011;
			4'h3: z = ~7'b1001111;
			4'h4: z = ~7'b1100110;
			4'h5: z = ~7'b1101101;
			4'h6: z = ~7'b1111101;
			4'h7: z = ~7'b0000111;
			4'h8: z = ~7'b1111111;
			4'h9: z = ~7'b1100111;
			4'hA: z = ~7'b1110111;
			4'hB: z = ~7'b1111100;  // Lower-case b
			4'hC: z = ~7'b1011000;  // Lower-case c
			4'hD: z = ~7'b1011110;  // Lower-case d
			4'hE: z = ~7'b1111001;
			4'hF: z = ~7'b1110001;
			default: z = '1;  // Blank
		endcase
	end

endmodule

/* hdl/boardTop.sv */
`include "panel_defs.svh"

module boardTop (
	input  logic                  clk,
	input  logic                  reset,
	input  panelPkg::switchWord_u switches,
	input  logic                  ldOp,
	input  logic                  ldImm,
	input  logic                  ldReg,
	input  logic                  ldCtrl,
	input  logic                  exec,
	output aluPkg::flags_t        flags,
	output logic [`SEG_W-1:0]     seg3,
	output logic [`SEG_W-1:0]     seg2,
	output logic [`SEG_W-1:0]     seg1,
	output logic [`SEG_W-1:0]     seg0
);

	import panelPkg::*;

	panelCtrl_t                            ctrl;
	logic [`DATA_W-1:0]                    result;
	logic [`DIGITS-1:0][`NIBBLE_W-1:0]     nibble;  // nibble[3] is the leftmost digit

	assign nibble = result;

	panelLatch latch_i (
		.clk      (clk),
		.reset    (reset),
		.switches (switches),
		.ldOp     (ldOp),
		.ldImm    (ldImm),
		.ldReg    (ldReg),
		.ldCtrl   (ldCtrl),
		.ctrl     (ctrl)
	);

	regFileAlu exec_i (
		.clk    (clk),
		.reset  (reset),
		.exec   (exec),
		.ctrl   (ctrl),
		.result (result),
		.flags  (flags)
	);

	hexTo7Seg seg3_i (.x(nibble[3]), .z(seg3));
	hexTo7Seg seg2_i (.x(nibble[2]), .z(seg2));
	hexTo7Seg seg1_i (.x(nibble[1]), .z(seg1));
	hexTo7Seg seg0_i (.x(nibble[0]), .z(seg0));

endmodule

/* verif/regFileAlu_checker.sv */
`include "panel_defs.svh"

module regFileAlu_checker (
	input logic                 clk,
	input logic                 reset,
	input logic                 exec,
	input panelPkg::panelCtrl_t ctrl,
	input logic [`DATA_W-1:0]   result,
	input aluPkg::flags_t       flags,
	input logic [`DATA_W-1:0]   destData,
	input logic [`DATA_W-1:0]   srcData
);

	import aluPkg::*;

	logic qualified;

	// Exec the unit may act on
	assign qualified = exec && ctrl.enable && !ctrl.clear && (ctrl.opCode <= OP_CMP);

	resultHeld: assert property (
		@(posedge clk) disable iff (reset)
		!qualified |=> $stable(result) && $stable(flags)
	) else $error("result or flags changed without a qualified exec");

	// One edge after clear is seen the file is already wiped
	clearReadsZero: assert property (
		@(posedge clk) disable iff (reset)
		ctrl.clear && $past(ctrl.clear) |-> (destData == '0) && (srcData == '0)
	) else $error("register read data not zero while clear is held");

endmodule

bind regFileAlu regFileAlu_checker chk_i (
	.clk      (clk),
	.reset    (reset),
	.exec     (exec),
	.ctrl     (ctrl),
	.result   (result),
	.flags    (flags),
	.destData (destData),
	.srcData  (srcData)
);

/* verif/boardTop_tb.sv */
`include "panel_defs.svh"

module boardTop_tb;

	import aluPkg::*;
	import panelPkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_ROWS     = 23;
	localparam int RAND_COUNT   = 40;
	localparam int TIMEOUT      = (NUM_ROWS + RAND_COUNT) * 12 * CLK_PERIOD
	                              + RESET_CYCLES * CLK_PERIOD;

	// Strobe bits as {exec, ldCtrl, ldReg, ldImm, ldOp}
	localparam logic [4:0] LD_OP   = 5'b00001;
	localparam logic [4:0] LD_IMM  = 5'b00010;
	localparam logic [4:0] LD_REG  = 5'b00100;
	localparam logic [4:0] LD_CTRL = 5'b01000;
	localparam logic [4:0] EXEC    = 5'b10000;

	typedef struct packed {
		logic [`OP_W-1:0]   op;
		logic               immSel;
		logic [`REG_AW-1:0] dest;
		logic [`REG_AW-1:0] src;
		logic [`SW_W-1:0]   imm;
		logic               en;
		logic               clr;
		logic [`DATA_W-1:0] expRes;
		flags_t             expFlags;  // {carry, low, overflow, zero, negative}
	} row_t;

	logic               clk;
	logic               reset;
	switchWord_u        switches;
	logic               ldOp;
	logic               ldImm;
	logic               ldReg;
	logic               ldCtrl;
	logic               exec;
	flags_t             flags;
	logic [`SEG_W-1:0]  seg3;
	logic [`SEG_W-1:0]  seg2;
	logic [`SEG_W-1:0]  seg1;
	logic [`SEG_W-1:0]  seg0;

	row_t               rows [NUM_ROWS];
	logic [`DATA_W-1:0] shadow [`REG_COUNT];  // Model copy of the register file
	logic [`DATA_W-1:0] lastRes;
	flags_t             lastFlags;
	logic [31:0]        seed;
	int                 errors;
	int                 checks;

	boardTop dut_i (
		.clk      (clk),
		.reset    (reset),
		.switches (switches),
		.ldOp     (ldOp),
		.ldImm    (ldImm),
		.ldReg    (ldReg),
		.ldCtrl   (ldCtrl),
		.exec     (exec),
		.flags    (flags),
		.seg3     (seg3),
		.seg2     (seg2),
		.seg1     (seg1),
		.seg0     (seg0)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// Active-low gfedcba back to a nibble, bit 4 set when the pattern is known
	function automatic logic [4:0] segToHex(input logic [`SEG_W-1:0] seg);
		case (~seg)
			7'h3F: return 5'h10;
			7'h06: return 5'h11;
			7'h5B: return 5'h12;
			7'h4F: return 5'h13;
			7'h66: return 5'h14;
			7'h6D: return 5'h15;
			7'h7D: return 5'h16;
			7'h07: return 5'h17;
			7'h7F: return 5'h18;
			7'h67: return 5'h19;
			7'h77: return 5'h1A;
			7'h7C: return 5'h1B;
			7'h58: return 5'h1C;
			7'h5E: return 5'h1D;
			7'h79: return 5'h1E;
			7'h71: return 5'h1F;
			default: return 5'h00;
		endcase
	endfunction

	task automatic checkOutputs(input logic [`DATA_W-1:0] expRes, input flags_t expFlags,
	                            input string tag);
		logic [4:0] d3;
		logic [4:0] d2;
		logic [4:0] d1;
		logic [4:0] d0;
		d3 = segToHex(seg3);
		d2 = segToHex(seg2);
		d1 = segToHex(seg1);
		d0 = segToHex(seg0);
		if (!(d3[4] && d2[4] && d1[4] && d0[4])) begin
			errors++;
			$display("Display shows a pattern that is no hex digit (%s, time %0t)", tag, $time);
		end else begin
			checkValue({16'b0, d3[3:0], d2[3:0], d1[3:0], d0[3:0]}, {16'b0, expRes},
			           {tag, " result"});
		end
		checkValue({27'b0, flags}, {27'b0, expFlags}, {tag, " flags"});
	endtask

	// Reference model, also keeps the shadow file in step with the DUT
	task automatic modelRow(input row_t r, output logic [`DATA_W-1:0] expRes,
	                        output flags_t expFlags);
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] val;
		flags_t             f;
		int                 wide;
		int                 sgn;
		a = shadow[r.dest];
		b = r.immSel ? {{(`DATA_W-`SW_W){r.imm[`SW_W-1]}}, r.imm} : shadow[r.src];
		val = '0;
		f = '0;
		if (r.clr) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				shadow[i] = '0;
			end
		end else if (r.en && (r.op < 5'd8)) begin
			case (r.op)
				OP_ADD: begin
					wide = int'(a) + int'(b);
					sgn = int'($signed(a)) + int'($signed(b));
					val = wide[15:0];
					f.carry = (wide > 65535);
					f.overflow = (sgn > 32767) || (sgn < -32768);
				end
				OP_SUB, OP_CMP: begin
					sgn = int'($signed(a)) - int'($signed(b));
					val = a - b;
					f.carry = (a < b);  // Borrow
					f.low = (a < b);
					f.overflow = (sgn > 32767) || (sgn < -32768);
				end
				OP_AND: val = a & b;
				OP_OR:  val = a | b;
				OP_XOR: val = a ^ b;
				OP_MOV: val = b;
				OP_LSH: val = a << b[3:0];
				default: val = '0;
			endcase
			f.zero = (val == '0);
			f.negative = val[`DATA_W-1];
			if (r.op != OP_CMP) begin
				shadow[r.dest] = val;
			end
			lastRes = val;
			lastFlags = f;
		end
		expRes = lastRes;
		expFlags = lastFlags;
	endtask

	task automatic pulse(input logic [`SW_W-1:0] value, input logic [4:0] which);
		switches.raw = value;
		{exec, ldCtrl, ldReg, ldImm, ldOp} = which;
		@(posedge clk);
		#DRIVE_DELAY;
		{exec, ldCtrl, ldReg, ldImm, ldOp} = 5'b0;
	endtask

	task automatic runRow(input row_t r, input logic fromTable, input int index);
		logic [`DATA_W-1:0] expRes;
		flags_t             expFlags;
		string              tag;
		modelRow(r, expRes, expFlags);
		if (fromTable) begin
			expRes = r.expRes;
			expFlags = r.expFlags;
			tag = $sformatf("table row %0d", index);
		end else begin
			tag = $sformatf("random row %0d", index);
		end
		pulse({r.immSel, {(`SW_W-`OP_W-1){1'b0}}, r.op}, LD_OP);
		pulse(r.imm, LD_IMM);
		pulse({r.dest, 2'b00, r.src}, LD_REG);
		pulse({8'b0, r.en, r.clr}, LD_CTRL);
		pulse('0, EXEC);
		@(negedge clk);  // One cycle after exec
		checkOutputs(expRes, expFlags, tag);
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic fillTable();
		rows[0]  = '{OP_MOV, 1'b1, 4'd1, 4'd0, 10'h005, 1'b1, 1'b0, 16'h0005, 5'b00000};
		rows[1]  = '{OP_MOV, 1'b1, 4'd2, 4'd0, 10'h3FF, 1'b1, 1'b0, 16'hFFFF, 5'b00001};
		rows[2]  = '{OP_MOV, 1'b1, 4'd3, 4'd0, 10'h1FF, 1'b1, 1'b0, 16'h01FF, 5'b00000};
		rows[3]  = '{OP_ADD, 1'b0, 4'd1, 4'd2, 10'h000, 1'b1, 1'b0, 16'h0004, 5'b10000};
		rows[4]  = '{OP_SUB, 1'b0, 4'd3, 4'd1, 10'h000, 1'b1, 1'b0, 16'h01FB, 5'b00000};
		rows[5]  = '{OP_SUB, 1'b0, 4'd1, 4'd3, 10'h000, 1'b1, 1'b0, 16'hFE09, 5'b11001};
		rows[6]  = '{OP_AND, 1'b0, 4'd2, 4'd3, 10'h000, 1'b1, 1'b0, 16'h01FB, 5'b00000};
		rows[7]  = '{OP_OR,  1'b0, 4'd2, 4'd1, 10'h000, 1'b1, 1'b0, 16'hFFFB, 5'b00001};
		rows[8]  = '{OP_XOR, 1'b0, 4'd2, 4'd2, 10'h000, 1'b1, 1'b0, 16'h0000, 5'b00010};
		rows[9]  = '{OP_LSH, 1'b0, 4'd3, 4'd1, 10'h000, 1'b1, 1'b0, 16'hF600, 5'b00001};
		rows[10] = '{OP_MOV, 1'b1, 4'd4, 4'd0, 10'h1FF, 1'b1, 1'b0, 16'h01FF, 5'b00000};
		rows[11] = '{OP_LSH, 1'b1, 4'd4, 4'd0, 10'h006, 1'b1, 1'b0, 16'h7FC0, 5'b00000};
		rows[12] = '{OP_ADD, 1'b0, 4'd4, 4'd4, 10'h000, 1'b1, 1'b0, 16'hFF80, 5'b00101};
		rows[13] = '{OP_ADD, 1'b1, 4'd4, 4'd0, 10'h080, 1'b1, 1'b0, 16'h0000, 5'b10010};
		rows[14] = '{OP_CMP, 1'b1, 4'd1, 4'd0, 10'h3FF, 1'b1, 1'b0, 16'hFE0A, 5'b11001};
		rows[15] = '{OP_MOV, 1'b0, 4'd5, 4'd1, 10'h000, 1'b1, 1'b0, 16'hFE09, 5'b00001};
		rows[16] = '{5'h1F,  1'b1, 4'd6, 4'd0, 10'h012, 1'b1, 1'b0, 16'hFE09, 5'b00001};
		rows[17] = '{OP_CMP, 1'b0, 4'd5, 4'd1, 10'h000, 1'b1, 1'b0, 16'h0000, 5'b00010};
		rows[18] = '{OP_ADD, 1'b0, 4'd5, 4'd5, 10'h000, 1'b0, 1'b0, 16'h0000, 5'b00010};
		rows[19] = '{OP_MOV, 1'b1, 4'd1, 4'd3, 10'h123, 1'b1, 1'b1, 16'h0000, 5'b00010};
		rows[20] = '{OP_MOV, 1'b1, 4'd8, 4'd0, 10'h0AB, 1'b1, 1'b0, 16'h00AB, 5'b00000};
		rows[21] = '{OP_MOV, 1'b0, 4'd7, 4'd1, 10'h000, 1'b1, 1'b0, 16'h0000, 5'b00010};
		rows[22] = '{OP_ADD, 1'b0, 4'd8, 4'd3, 10'h000, 1'b1, 1'b0, 16'h00AB, 5'b00000};
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		switches = '0;
		{exec, ldCtrl, ldReg, ldImm, ldOp} = 5'b0;
		seed = 32'd78;
		errors = 0;
		checks = 0;
		lastRes = '0;
		lastFlags = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			shadow[i] = '0;
		end
		fillTable();

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(negedge clk);
		checkOutputs('0, '0, "after reset");  // All digits 0, flags clear
		@(posedge clk);
		#DRIVE_DELAY;

		for (int i = 0; i < NUM_ROWS; i++) begin
			runRow(rows[i], 1'b1, i);
		end

		for (int i = 0; i < RAND_COUNT; i++) begin
			row_t        r;
			logic [31:0] r1;
			logic [31:0] r2;
			r1 = nextRand();
			r2 = nextRand();
			r.op = {2'b00, r1[18:16]};  // Valid opcodes only
			r.immSel = r1[19];
			r.dest = r1[23:20];
			r.src = r1[27:24];
			r.imm = r2[25:16];
			r.en = 1'b1;
			r.clr = 1'b0;
			r.expRes = '0;
			r.expFlags = '0;
			runRow(r, 1'b0, i);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout: the run did not finish within %0d time units", TIMEOUT);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
hdl/aluPkg.sv
hdl/panelPkg.sv
hdl/panelLatch.sv
hdl/regFile.sv
hdl/alu.sv
hdl/regFileAlu.sv
hdl/hexTo7Seg.sv
hdl/boardTop.sv
verif/regFileAlu_checker.sv
verif/boardTop_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module boardTop_tb -f src.f
	@out="$$(./obj_dir/VboardTop_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
